/* filelist.f */
+incdir+tb
source/exec_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_unit.sv
source/exec_complete.sv
source/exec_stage.sv
tb/exec_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f filelist.f --top-module exec_stage_tb \
    -Mdir obj_dir -o exec_stage_sim \
    && ./obj_dir/exec_stage_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "^Regression passed$" sim.log \
    && { echo "run.sh: PASS"; exit 0; } \
    || { echo "run.sh: FAIL"; exit 1; }

/* source/alu.sv */
`timescale 1ns/100ps

module alu #(
    parameter int tag_width = 6
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      in_valid,
    input  logic [tag_width-1:0]      in_tag,
    input  logic [exec_pkg::xlen-1:0] opa,
    input  logic [exec_pkg::xlen-1:0] opb,
    input  exec_pkg::alu_func_e       func,
    output logic                      valid,
    output logic [tag_width-1:0]      tag,
    output logic [exec_pkg::xlen-1:0] result
);
    import exec_pkg::*;

    logic [xlen-1:0] next_result;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = opb[4:0];   // rv32 shifts use five bits
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            alu_add:  next_result = opa + opb;
            alu_sub:  next_result = opa - opb;
            alu_and:  next_result = opa & opb;
            alu_or:   next_result = opa | opb;
            alu_xor:  next_result = opa ^ opb;
            alu_slt:  next_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: next_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:  next_result = opa << shamt;
            alu_srl:  next_result = opa >> shamt;
            alu_sra:  next_result = $signed(opa) >>> shamt;
            default:  next_result = alu_filler;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= in_valid;    // drops when nothing accepted
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            tag    <= in_tag;
            result <= next_result;
        end
    end

    // issuer must hand over a decoded function with every valid op
    func_legal: assert property (@(posedge clock) disable iff (reset)
        in_valid |-> func inside {alu_add, alu_sub, alu_and, alu_or, alu_xor,
                                  alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra})
        else $error("alu: illegal func %0h with in_valid", func);

endmodule

/* source/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit #(
    parameter int tag_width = 6
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      in_valid,
    input  logic [tag_width-1:0]      in_tag,
    input  exec_pkg::br_func_e        func,
    input  logic [exec_pkg::xlen-1:0] rs1,
    input  logic [exec_pkg::xlen-1:0] rs2,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::xlen-1:0] pc,
    input  logic                      pred_taken,
    output logic                      valid,
    output logic [tag_width-1:0]      tag,
    output logic                      taken,
    output logic                      link,
    output logic [exec_pkg::xlen-1:0] target,
    output logic [exec_pkg::xlen-1:0] npc,
    output logic                      pred_out
);
    import exec_pkg::*;

    logic            next_taken;
    logic            is_jump;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] next_target;

    always_comb begin
        case (func)
            br_beq:  next_taken = (rs1 == rs2);
            br_bne:  next_taken = (rs1 != rs2);
            br_blt:  next_taken = $signed(rs1) < $signed(rs2);
            br_bge:  next_taken = $signed(rs1) >= $signed(rs2);
            br_bltu: next_taken = rs1 < rs2;
            br_bgeu: next_taken = rs1 >= rs2;
            default: next_taken = 1'b1;    // jal, jalr
        endcase
    end

    assign is_jump     = (func == br_jal) || (func == br_jalr);
    assign jalr_sum    = rs1 + imm;
    assign next_target = (func == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            tag      <= in_tag;
            taken    <= next_taken;
            link     <= is_jump;   // rd gets npc
            target   <= next_target;
            npc      <= pc + npc_offset;
            pred_out <= pred_taken;
        end
    end

    // pc from fetch plus an even immediate must stay on a halfword
    target_aligned: assert property (@(posedge clock) disable iff (reset)
        (in_valid && !stall && next_taken) |=> (target[0] == 1'b0))
        else $error("branch_unit: misaligned target %h", target);

endmodule

/* source/exec_complete.sv */
`timescale 1ns/100ps

module exec_complete #(
    parameter int tag_width = 6
) (
    input  logic                      alu_valid,
    input  logic [tag_width-1:0]      alu_tag,
    input  logic [exec_pkg::xlen-1:0] alu_result,
    input  logic                      br_valid,
    input  logic [tag_width-1:0]      br_tag,
    input  logic                      br_taken,
    input  logic                      br_link,
    input  logic [exec_pkg::xlen-1:0] br_target,
    input  logic [exec_pkg::xlen-1:0] br_npc,
    input  logic                      br_pred_taken,
    output logic                      wb_valid,
    output logic [tag_width-1:0]      wb_tag,
    output logic [exec_pkg::xlen-1:0] wb_value,
    output logic                      redirect_valid,
    output logic [exec_pkg::xlen-1:0] redirect_pc
);

    logic mispredict;

    assign mispredict = br_taken != br_pred_taken;

    // only one unit can hold a result in a given cycle
    always_comb begin
        wb_valid = alu_valid || br_valid;
        if (br_valid) begin
            wb_tag = br_tag;
            if (br_link) begin
                wb_value = br_npc;     // jal/jalr link value
            end else begin
                wb_value = '0;         // plain branch just retires
            end
        end else begin
            wb_tag   = alu_tag;
            wb_value = alu_result;
        end
    end

    // resteer fetch when the outcome disagrees with the predictor
    always_comb begin
        redirect_valid = br_valid && mispredict;
        if (br_taken) begin
            redirect_pc = br_target;
        end else begin
            redirect_pc = br_npc;      // fall through
        end
    end

    // selector sends each op to exactly one unit, so their registers never overlap
    always_comb begin
        one_unit: assert (!(alu_valid && br_valid))
            else $error("exec_complete: alu and branch results collide");
    end

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

    // RV32 data path width
    localparam int xlen = 32;

    // instruction word width, also fixed by the ISA
    localparam int ilen = 32;

    // sequential pc step
    localparam logic [xlen-1:0] npc_offset = 32'd4;

    // filler values for select encodings outside the enum
    localparam logic [xlen-1:0] opa_filler = 32'hdeadface;
    localparam logic [xlen-1:0] opb_filler = 32'hfacefeed;
    localparam logic [xlen-1:0] alu_filler = 32'hfacebeec;

    // ALU A operand source
    typedef enum logic [1:0] {
        opa_rs1  = 2'h0,
        opa_npc  = 2'h1,
        opa_pc   = 2'h2,
        opa_zero = 2'h3
    } opa_select_e;

    // ALU B operand source
    typedef enum logic [2:0] {
        opb_rs2   = 3'h0,
        opb_i_imm = 3'h1,
        opb_s_imm = 3'h2,
        opb_b_imm = 3'h3,
        opb_u_imm = 3'h4,
        opb_j_imm = 3'h5
    } opb_select_e;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,   // signed compare
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9    // arithmetic right
    } alu_func_e;

    // conditional branches plus the two jumps
    typedef enum logic [2:0] {
        br_beq  = 3'h0,
        br_bne  = 3'h1,
        br_blt  = 3'h2,
        br_bge  = 3'h3,
        br_bltu = 3'h4,
        br_bgeu = 3'h5,
        br_jal  = 3'h6,
        br_jalr = 3'h7
    } br_func_e;

    // which unit takes the micro-op
    typedef enum logic {
        fu_alu    = 1'b0,
        fu_branch = 1'b1
    } fu_class_e;

endpackage

/* source/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage #(
    parameter int tag_width = 6
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      issue_valid,
    input  exec_pkg::fu_class_e       issue_class,
    input  exec_pkg::opa_select_e     issue_opa_select,
    input  exec_pkg::opb_select_e     issue_opb_select,
    input  exec_pkg::alu_func_e       issue_alu_func,
    input  exec_pkg::br_func_e        issue_br_func,
    input  logic [exec_pkg::ilen-1:0] issue_inst,
    input  logic [exec_pkg::xlen-1:0] issue_pc,
    input  logic [exec_pkg::xlen-1:0] issue_rs1_value,
    input  logic [exec_pkg::xlen-1:0] issue_rs2_value,
    input  logic [tag_width-1:0]      issue_tag,
    input  logic                      issue_pred_taken,
    output logic                      wb_valid,
    output logic [tag_width-1:0]      wb_tag,
    output logic [exec_pkg::xlen-1:0] wb_value,
    output logic                      redirect_valid,
    output logic [exec_pkg::xlen-1:0] redirect_pc
);
    import exec_pkg::*;

    // selector to units
    logic            alu_in_valid;
    logic [xlen-1:0] opa, opb;
    alu_func_e       alu_func;
    logic            br_in_valid;
    br_func_e        br_func;
    logic [xlen-1:0] br_rs1, br_rs2, br_imm, br_pc;

    // units to completion
    logic                 alu_valid;
    logic [tag_width-1:0] alu_tag;
    logic [xlen-1:0]      alu_result;
    logic                 br_valid;
    logic [tag_width-1:0] br_tag;
    logic                 br_taken, br_link, br_pred_taken;
    logic [xlen-1:0]      br_target, br_npc;

    operand_select u_operand_select (
        .issue_valid(issue_valid), .issue_class(issue_class),
        .issue_opa_select(issue_opa_select), .issue_opb_select(issue_opb_select),
        .issue_alu_func(issue_alu_func), .issue_br_func(issue_br_func),
        .issue_inst(issue_inst), .issue_pc(issue_pc),
        .issue_rs1_value(issue_rs1_value), .issue_rs2_value(issue_rs2_value),
        .alu_in_valid(alu_in_valid), .opa(opa), .opb(opb), .alu_func(alu_func),
        .br_in_valid(br_in_valid), .br_func(br_func),
        .br_rs1(br_rs1), .br_rs2(br_rs2), .br_imm(br_imm), .br_pc(br_pc)
    );

    alu #(.tag_width(tag_width)) u_alu (
        .clock(clock), .reset(reset), .stall(stall),
        .in_valid(alu_in_valid), .in_tag(issue_tag),
        .opa(opa), .opb(opb), .func(alu_func),
        .valid(alu_valid), .tag(alu_tag), .result(alu_result)
    );

    branch_unit #(.tag_width(tag_width)) u_branch_unit (
        .clock(clock), .reset(reset), .stall(stall),
        .in_valid(br_in_valid), .in_tag(issue_tag), .func(br_func),
        .rs1(br_rs1), .rs2(br_rs2), .imm(br_imm), .pc(br_pc),
        .pred_taken(issue_pred_taken),
        .valid(br_valid), .tag(br_tag), .taken(br_taken), .link(br_link),
        .target(br_target), .npc(br_npc), .pred_out(br_pred_taken)
    );

    exec_complete #(.tag_width(tag_width)) u_exec_complete (
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_result(alu_result),
        .br_valid(br_valid), .br_tag(br_tag), .br_taken(br_taken),
        .br_link(br_link), .br_target(br_target), .br_npc(br_npc),
        .br_pred_taken(br_pred_taken),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

endmodule

/* source/operand_select.sv */
`timescale 1ns/100ps

module operand_select (
    input  logic                      issue_valid,
    input  exec_pkg::fu_class_e       issue_class,
    input  exec_pkg::opa_select_e     issue_opa_select,
    input  exec_pkg::opb_select_e     issue_opb_select,
    input  exec_pkg::alu_func_e       issue_alu_func,
    input  exec_pkg::br_func_e        issue_br_func,
    input  logic [exec_pkg::ilen-1:0] issue_inst,
    input  logic [exec_pkg::xlen-1:0] issue_pc,
    input  logic [exec_pkg::xlen-1:0] issue_rs1_value,
    input  logic [exec_pkg::xlen-1:0] issue_rs2_value,
    output logic                      alu_in_valid,
    output logic [exec_pkg::xlen-1:0] opa,
    output logic [exec_pkg::xlen-1:0] opb,
    output exec_pkg::alu_func_e       alu_func,
    output logic                      br_in_valid,
    output exec_pkg::br_func_e        br_func,
    output logic [exec_pkg::xlen-1:0] br_rs1,
    output logic [exec_pkg::xlen-1:0] br_rs2,
    output logic [exec_pkg::xlen-1:0] br_imm,
    output logic [exec_pkg::xlen-1:0] br_pc
);
    import exec_pkg::*;

    logic [xlen-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [xlen-1:0] npc;

    assign i_imm = {{20{issue_inst[31]}}, issue_inst[31:20]};
    assign s_imm = {{20{issue_inst[31]}}, issue_inst[31:25], issue_inst[11:7]};
    assign b_imm = {{19{issue_inst[31]}}, issue_inst[31], issue_inst[7],
                    issue_inst[30:25], issue_inst[11:8], 1'b0};
    assign u_imm = {issue_inst[31:12], 12'h000};
    assign j_imm = {{11{issue_inst[31]}}, issue_inst[31], issue_inst[19:12],
                    issue_inst[20], issue_inst[30:21], 1'b0};

    assign npc = issue_pc + npc_offset;

    always_comb begin
        case (issue_opa_select)
            opa_rs1:  opa = issue_rs1_value;
            opa_npc:  opa = npc;
            opa_pc:   opa = issue_pc;
            opa_zero: opa = '0;    // lui
            default:  opa = opa_filler;
        endcase
    end

    always_comb begin
        case (issue_opb_select)
            opb_rs2:   opb = issue_rs2_value;
            opb_i_imm: opb = i_imm;
            opb_s_imm: opb = s_imm;
            opb_b_imm: opb = b_imm;
            opb_u_imm: opb = u_imm;
            opb_j_imm: opb = j_imm;
            default:   opb = opb_filler;
        endcase
    end

    // branch unit immediate depends on the jump kind
    always_comb begin
        case (issue_br_func)
            br_jal:  br_imm = j_imm;
            br_jalr: br_imm = i_imm;
            default: br_imm = b_imm;
        endcase
    end

    assign alu_in_valid = issue_valid && (issue_class == fu_alu);
    assign br_in_valid  = issue_valid && (issue_class == fu_branch);
    assign alu_func     = issue_alu_func;
    assign br_func      = issue_br_func;
    assign br_rs1       = issue_rs1_value;
    assign br_rs2       = issue_rs2_value;
    assign br_pc        = issue_pc;

endmodule

/* tb/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    else return s >> 1;
endfunction

function automatic logic [31:0] imm_i(input logic [31:0] inst);
    logic [11:0] v;
    v = inst[31:20];
    return 32'($signed(v));
endfunction

function automatic logic [31:0] imm_b(input logic [31:0] inst);
    logic [12:0] v;
    v = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    return 32'($signed(v));
endfunction

function automatic logic [31:0] imm_j(input logic [31:0] inst);
    logic [20:0] v;
    v = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return 32'($signed(v));
endfunction

function automatic logic [31:0] imm_s(input logic [31:0] inst);
    logic [11:0] v;
    v = {inst[31:25], inst[11:7]};
    return 32'($signed(v));
endfunction

function automatic logic [31:0] alu_ref(input alu_func_e f, input logic [31:0] a, b);
    logic [31:0] bias;
    bias = 32'h80000000;   // signed compare by flipping the sign bit
    case (f)
        alu_add:  return a + b;
        alu_sub:  return a - b;
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_slt:  return ((a ^ bias) < (b ^ bias)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        alu_sll:  return a << b[4:0];
        alu_srl:  return a >> b[4:0];
        default:  return a[31] ? ~((~a) >> b[4:0]) : a >> b[4:0];
    endcase
endfunction

function automatic logic branch_ref(input br_func_e f, input logic [31:0] a, b);
    logic lt;
    lt = (a ^ 32'h80000000) < (b ^ 32'h80000000);
    case (f)
        br_beq:  return a == b;
        br_bne:  return a != b;
        br_blt:  return lt;
        br_bge:  return !lt;
        br_bltu: return a < b;
        br_bgeu: return a >= b;
        default: return 1'b1;
    endcase
endfunction

`endif

/* tb/exec_stage_tb.sv */
`timescale 1ns/100ps

module exec_stage_tb;
    import exec_pkg::*;
    `include "exec_model.svh"

    logic        clock, reset, stall, issue_valid, issue_pred_taken;
    fu_class_e   issue_class;
    opa_select_e issue_opa_select;
    opb_select_e issue_opb_select;
    alu_func_e   issue_alu_func;
    br_func_e    issue_br_func;
    logic [31:0] issue_inst, issue_pc, issue_rs1_value, issue_rs2_value;
    logic [5:0]  issue_tag;
    logic        wb_valid, redirect_valid;
    logic [5:0]  wb_tag;
    logic [31:0] wb_value, redirect_pc;

    logic [31:0] lfsr_state = 32'd69983;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic        hung = 1'b0;

    exec_stage #(.tag_width(6)) dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // a stuck wait raises hung and parks, this ends the run
    initial begin
        wait (hung);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, act);
        checks++;
        if (exp !== act) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_alu(input logic [5:0] tag, input opa_select_e a_sel,
                             input opb_select_e b_sel, input alu_func_e f,
                             input logic [31:0] inst, pc, r1, r2);
        issue_valid      <= 1'b1;
        issue_class      <= fu_alu;
        issue_opa_select <= a_sel;
        issue_opb_select <= b_sel;
        issue_alu_func   <= f;
        issue_inst       <= inst;
        issue_pc         <= pc;
        issue_rs1_value  <= r1;
        issue_rs2_value  <= r2;
        issue_tag        <= tag;
        issue_pred_taken <= 1'b0;
    endtask

    task automatic drive_branch(input logic [5:0] tag, input br_func_e f,
                                input logic [31:0] inst, pc, r1, r2, input logic pred);
        issue_valid      <= 1'b1;
        issue_class      <= fu_branch;
        issue_br_func    <= f;
        issue_inst       <= inst;
        issue_pc         <= pc;
        issue_rs1_value  <= r1;
        issue_rs2_value  <= r2;
        issue_tag        <= tag;
        issue_pred_taken <= pred;
    endtask

    // first edge accepts the op, so issue drops there
    task automatic wait_wb(output int cycles);
        cycles = 0;
        do begin
            @(posedge clock);
            if (cycles == 0) issue_valid <= 1'b0;
            cycles++;
            #1;
        end while (!wb_valid && cycles < 20);
        if (!wb_valid) begin
            $display("timeout: wb_valid never rose for tag %h", issue_tag);
            hung = 1'b1;
            forever @(posedge clock);
        end
    endtask

    task automatic run_alu(input opa_select_e a_sel, input opb_select_e b_sel,
                           input alu_func_e f);
        logic [31:0] inst, pc, r1, r2, a, b;
        logic [5:0]  tag;
        int          cycles;
        inst = rand_bits(32);
        pc   = rand_bits(30) << 2;
        r1   = rand_bits(32);
        r2   = rand_bits(32);
        tag  = 6'(rand_bits(6));
        case (a_sel)
            opa_rs1: a = r1;
            opa_npc: a = pc + 32'd4;
            opa_pc:  a = pc;
            default: a = '0;
        endcase
        case (b_sel)
            opb_rs2:   b = r2;
            opb_i_imm: b = imm_i(inst);
            opb_s_imm: b = imm_s(inst);
            opb_b_imm: b = imm_b(inst);
            opb_u_imm: b = inst & 32'hfffff000;
            default:   b = imm_j(inst);
        endcase
        @(posedge clock);
        drive_alu(tag, a_sel, b_sel, f, inst, pc, r1, r2);
        wait_wb(cycles);
        check_value("wb_tag", 32'(tag), 32'(wb_tag));
        check_value("wb_value", alu_ref(f, a, b), wb_value);
        check_value("redirect_valid", 32'd0, 32'(redirect_valid));
    endtask

    task automatic run_branch(input br_func_e f, input logic [31:0] r1, r2,
                              input logic pred);
        logic [31:0] inst, pc, target;
        logic [5:0]  tag;
        logic        taken, jump;
        int          cycles;
        inst  = rand_bits(32);
        pc    = rand_bits(30) << 2;
        tag   = 6'(rand_bits(6));
        jump  = (f == br_jal) || (f == br_jalr);
        taken = branch_ref(f, r1, r2);
        if (f == br_jal) target = pc + imm_j(inst);
        else if (f == br_jalr) target = (r1 + imm_i(inst)) & ~32'd1;
        else target = pc + imm_b(inst);
        @(posedge clock);
        drive_branch(tag, f, inst, pc, r1, r2, pred);
        wait_wb(cycles);
        check_value("wb_tag", 32'(tag), 32'(wb_tag));
        check_value("wb_value", jump ? pc + 32'd4 : 32'd0, wb_value);
        check_value("redirect_valid", 32'(taken != pred), 32'(redirect_valid));
        check_value("redirect_pc", taken ? target : pc + 32'd4, redirect_pc);
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset_add();
        int          e, cycles;
        logic [31:0] r1, r2;
        e  = errors;
        r1 = rand_bits(32);
        r2 = rand_bits(32);
        check_value("wb_valid", 32'd0, 32'(wb_valid));
        check_value("redirect_valid", 32'd0, 32'(redirect_valid));
        @(posedge clock);
        drive_alu(6'h05, opa_rs1, opb_rs2, alu_add, 32'h0, 32'h100, r1, r2);
        wait_wb(cycles);
        check_value("latency", 32'd1, 32'(cycles));
        check_value("wb_tag", 32'h05, 32'(wb_tag));
        check_value("wb_value", r1 + r2, wb_value);
        report("reset_add", e);
    endtask

    task automatic test_alu_funcs();
        int e;
        e = errors;
        for (int f = 0; f < 10; f++)
            for (int s = 0; s < 6; s++)
                run_alu(opa_rs1, opb_select_e'(3'(s)), alu_func_e'(4'(f)));
        run_alu(opa_zero, opb_u_imm, alu_add);   // lui
        run_alu(opa_pc, opb_u_imm, alu_add);     // auipc
        run_alu(opa_npc, opb_i_imm, alu_add);    // npc operand
        report("alu_funcs", e);
    endtask

    task automatic test_branches();
        int          e;
        logic [31:0] x, y;
        e = errors;
        for (int f = 0; f < 6; f++)
            for (int rel = 0; rel < 3; rel++)
                for (int p = 0; p < 2; p++) begin
                    x = rand_bits(30);
                    y = x + rand_bits(16) + 32'd1;   // x < y
                    if (p == 1) x = x - 32'h40000000;   // negative x flips unsigned order
                    if (rel == 0) run_branch(br_func_e'(3'(f)), x, x, p[0]);
                    else if (rel == 1) run_branch(br_func_e'(3'(f)), x, y, p[0]);
                    else run_branch(br_func_e'(3'(f)), y, x, p[0]);
                end
        report("branches", e);
    endtask

    task automatic test_jumps();
        int e;
        e = errors;
        for (int p = 0; p < 2; p++) begin
            run_branch(br_jal, rand_bits(32), rand_bits(32), p[0]);
            run_branch(br_jalr, rand_bits(32), rand_bits(32), p[0]);
        end
        report("jumps", e);
    endtask

    task automatic test_stream_stall();
        int          e, cycles;
        logic [31:0] a [4];
        logic [31:0] b [4];
        logic [31:0] held;
        e = errors;
        for (int k = 0; k < 4; k++) begin
            a[k] = rand_bits(32);
            b[k] = rand_bits(32);
        end
        for (int k = 0; k < 4; k++) begin
            @(posedge clock);
            drive_alu(6'(k + 8), opa_rs1, opb_rs2, alu_sub, 32'h0, 32'h0, a[k], b[k]);
            if (k > 0) begin
                #1;
                check_value("wb_valid", 32'd1, 32'(wb_valid));
                check_value("wb_tag", 32'(k + 7), 32'(wb_tag));
                check_value("wb_value", a[k-1] - b[k-1], wb_value);
            end
        end
        wait_wb(cycles);
        check_value("wb_tag", 32'd11, 32'(wb_tag));
        check_value("wb_value", a[3] - b[3], wb_value);
        // op a accepted, then b held behind a stall
        @(posedge clock);
        drive_alu(6'h2a, opa_rs1, opb_rs2, alu_xor, 32'h0, 32'h0, a[0], b[0]);
        @(posedge clock);
        drive_alu(6'h15, opa_rs1, opb_rs2, alu_or, 32'h0, 32'h0, a[1], b[1]);
        stall <= 1'b1;
        held = a[0] ^ b[0];
        for (int k = 0; k < 4; k++) begin
            if (k > 0) @(posedge clock);
            if (k == 3) stall <= 1'b0;
            #1;
            check_value("wb_valid", 32'd1, 32'(wb_valid));
            check_value("wb_tag", 32'h2a, 32'(wb_tag));
            check_value("wb_value", held, wb_value);
        end
        wait_wb(cycles);
        check_value("latency", 32'd1, 32'(cycles));
        check_value("wb_tag", 32'h15, 32'(wb_tag));
        check_value("wb_value", a[1] | b[1], wb_value);
        report("stream_stall", e);
    endtask

    initial begin
        reset            = 1'b1;
        stall            = 1'b0;
        issue_valid      = 1'b0;
        issue_class      = fu_alu;
        issue_opa_select = opa_rs1;
        issue_opb_select = opb_rs2;
        issue_alu_func   = alu_add;
        issue_br_func    = br_beq;
        issue_inst       = '0;
        issue_pc         = '0;
        issue_rs1_value  = '0;
        issue_rs2_value  = '0;
        issue_tag        = '0;
        issue_pred_taken = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        #1;
        test_reset_add();
        test_alu_funcs();
        test_branches();
        test_jumps();
        test_stream_stall();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
